// File: kitchen_pkg.sv
package kitchen_pkg;

    localparam int GRID_ROWS = 8;
    localparam int GRID_COLS = 13;

    typedef logic [3:0] grid_x_t;
    typedef logic [2:0] grid_y_t;
    typedef logic [3:0] timer_t;

    // lengths in frames
    localparam int CHOP_FRAMES = 5;
    localparam int COOK_FRAMES = 10;
    localparam int BURN_FRAMES = 5;   // cooked until fire

    localparam grid_x_t BOARD_X  = 4'd2;
    localparam grid_y_t BOARD_Y  = 3'd7;
    localparam grid_x_t CRATE_X  = 4'd0;
    localparam grid_y_t CRATE_Y0 = 3'd2;
    localparam grid_y_t CRATE_Y1 = 3'd3;
    localparam grid_x_t STOVE0_X = 4'd8;
    localparam grid_x_t STOVE1_X = 4'd10;
    localparam grid_y_t STOVE_Y  = 3'd0;
    localparam grid_x_t EXT_X    = 4'd0;
    localparam grid_y_t EXT_Y    = 3'd6;

    typedef enum logic [3:0] {
        G_EMPTY         = 4'd0,
        G_ONION_WHOLE   = 4'd1,
        G_ONION_CHOPPED = 4'd2,
        G_BOWL_EMPTY    = 4'd3,   // reserved
        G_BOWL_FULL     = 4'd4,   // reserved
        G_POT_EMPTY     = 4'd5,
        G_POT_RAW       = 4'd6,
        G_POT_COOKED    = 4'd7,
        G_FIRE          = 4'd9,
        G_EXTINGUISHER  = 4'd10
    } grid_obj_t;

    typedef enum logic [3:0] {
        P_NOTHING       = 4'd0,
        P_CHOPPING      = 4'd1,
        P_ONION_WHOLE   = 4'd2,
        P_ONION_CHOPPED = 4'd3,
        P_POT_EMPTY     = 4'd4,
        P_POT_RAW       = 4'd5,
        P_POT_COOKED    = 4'd6,
        P_EXT_OFF       = 4'd9,
        P_EXT_ON        = 4'd10
    } held_t;

    typedef enum logic [1:0] {LEFT, RIGHT, UP, DOWN} direction_t;

    typedef enum logic [2:0] {WELCOME, START, PLAY, PAUSE, FINISH} game_state_t;

    typedef enum logic [1:0] {S_NONE, S_RAW, S_COOKED, S_FIRE} stove_state_t;

    // row, then column, 4-bit object code per cell
    typedef logic [GRID_ROWS-1:0][GRID_COLS-1:0][3:0] grid_t;

endpackage

// File: frame_timer.sv
`timescale 1ns/1ps

module frame_timer #(
    parameter int GIVEN_TIME = kitchen_pkg::COOK_FRAMES
) (
    input  logic                vsync,
    input  logic                reset,
    input  logic                run,
    input  logic                restart,
    output kitchen_pkg::timer_t time_left
);

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            time_left <= kitchen_pkg::timer_t'(GIVEN_TIME);
        end else if (run && time_left != '0) begin
            time_left <= time_left - 1'b1;   // one step per frame, sticks at zero
        end
    end

endmodule

// File: stove_fsm.sv
`timescale 1ns/1ps

module stove_fsm #(
    parameter kitchen_pkg::grid_x_t STOVE_X = kitchen_pkg::STOVE0_X   // identifies the stove
) (
    input  logic                     vsync,
    input  logic                     reset,
    input  kitchen_pkg::game_state_t game_state,
    input  kitchen_pkg::grid_obj_t   cell_obj,
    output logic                     s_we,
    output kitchen_pkg::grid_obj_t   s_obj,
    output kitchen_pkg::timer_t      cook_left
);

    kitchen_pkg::stove_state_t state;
    kitchen_pkg::timer_t       burn_left;
    logic                      play;
    logic                      cook_done;
    logic                      burn_done;
    logic                      pot_gone;

    assign play     = (game_state == kitchen_pkg::PLAY);
    assign pot_gone = (cell_obj == kitchen_pkg::G_EMPTY);   // pot lifted off the stove

    assign cook_done = play && (state == kitchen_pkg::S_RAW) && (cook_left == '0) && !pot_gone;
    assign burn_done = play && (state == kitchen_pkg::S_COOKED) && (burn_left == '0)
                       && !pot_gone;

    // each timer sits full until its state is entered
    frame_timer #(.GIVEN_TIME(kitchen_pkg::COOK_FRAMES)) cook_timer (
        .vsync     (vsync),
        .reset     (reset),
        .run       (play && state == kitchen_pkg::S_RAW),
        .restart   (state != kitchen_pkg::S_RAW),
        .time_left (cook_left)
    );

    frame_timer #(.GIVEN_TIME(kitchen_pkg::BURN_FRAMES)) burn_timer (
        .vsync     (vsync),
        .reset     (reset),
        .run       (play && state == kitchen_pkg::S_COOKED),
        .restart   (state != kitchen_pkg::S_COOKED),
        .time_left (burn_left)
    );

    assign s_we  = cook_done || burn_done;
    assign s_obj = cook_done ? kitchen_pkg::G_POT_COOKED : kitchen_pkg::G_FIRE;

    always_ff @(posedge vsync) begin
        if (reset || game_state == kitchen_pkg::WELCOME) begin
            state <= kitchen_pkg::S_NONE;
        end else begin
            case (state)
                kitchen_pkg::S_NONE: begin
                    if (cell_obj == kitchen_pkg::G_POT_RAW) state <= kitchen_pkg::S_RAW;
                end
                kitchen_pkg::S_RAW: begin
                    if (pot_gone) begin
                        state <= kitchen_pkg::S_NONE;
                    end else if (cook_done) begin
                        state <= kitchen_pkg::S_COOKED;
                    end
                end
                kitchen_pkg::S_COOKED: begin
                    if (pot_gone) begin
                        state <= kitchen_pkg::S_NONE;
                    end else if (burn_done) begin
                        state <= kitchen_pkg::S_FIRE;
                    end
                end
                kitchen_pkg::S_FIRE: begin
                    if (cell_obj != kitchen_pkg::G_FIRE) state <= kitchen_pkg::S_NONE;
                end
                default: state <= kitchen_pkg::S_NONE;
            endcase
        end
    end

endmodule

// File: player_action.sv
`timescale 1ns/1ps

module player_action (
    input  logic                     vsync,
    input  logic                     reset,
    input  kitchen_pkg::game_state_t game_state,
    input  kitchen_pkg::grid_x_t     player_x,
    input  kitchen_pkg::grid_y_t     player_y,
    input  kitchen_pkg::direction_t  player_direction,
    input  kitchen_pkg::held_t       player_held,
    input  kitchen_pkg::grid_obj_t   front_obj,
    input  kitchen_pkg::grid_obj_t   board_obj,
    output logic                     p_we,
    output kitchen_pkg::grid_x_t     p_wx,
    output kitchen_pkg::grid_y_t     p_wy,
    output kitchen_pkg::grid_obj_t   p_obj,
    output kitchen_pkg::timer_t      chop_left
);

    kitchen_pkg::held_t old_held;
    logic               play;
    logic               front_valid;
    logic               at_crate;
    logic               chopping;
    logic               chop_done;
    logic               chop_start;

    always_ff @(posedge vsync) begin
        if (reset) old_held <= kitchen_pkg::P_NOTHING;
        else       old_held <= player_held;
    end

    // cell in front, flagged when it falls off the board
    always_comb begin
        front_valid = (player_x < kitchen_pkg::GRID_COLS);
        p_wx = player_x;
        p_wy = player_y;
        case (player_direction)
            kitchen_pkg::LEFT: begin
                if (player_x == '0) front_valid = 1'b0;
                else                p_wx = player_x - 1'b1;
            end
            kitchen_pkg::RIGHT: begin
                if (player_x >= kitchen_pkg::GRID_COLS - 1) front_valid = 1'b0;
                else                                        p_wx = player_x + 1'b1;
            end
            kitchen_pkg::UP: begin
                if (player_y == '0) front_valid = 1'b0;
                else                p_wy = player_y - 1'b1;
            end
            default: begin
                if (player_y == kitchen_pkg::GRID_ROWS - 1) front_valid = 1'b0;
                else                                        p_wy = player_y + 1'b1;
            end
        endcase
    end

    assign play     = (game_state == kitchen_pkg::PLAY);
    assign at_crate = (p_wx == kitchen_pkg::CRATE_X)
                      && (p_wy == kitchen_pkg::CRATE_Y0 || p_wy == kitchen_pkg::CRATE_Y1);

    // standing just above the board and facing it
    assign chopping = (player_held == kitchen_pkg::P_CHOPPING)
                      && (player_x == kitchen_pkg::BOARD_X)
                      && (player_y == kitchen_pkg::BOARD_Y - 1)
                      && (player_direction == kitchen_pkg::DOWN)
                      && (board_obj == kitchen_pkg::G_ONION_WHOLE);
    assign chop_start = (player_held == kitchen_pkg::P_CHOPPING)
                        && (old_held != kitchen_pkg::P_CHOPPING);
    assign chop_done  = play && chopping && (chop_left == '0);

    frame_timer #(.GIVEN_TIME(kitchen_pkg::CHOP_FRAMES)) chop_timer (
        .vsync     (vsync),
        .reset     (reset),
        .run       (play && chopping),
        .restart   (play && (chop_start || chop_done)),
        .time_left (chop_left)
    );

    always_comb begin
        p_we  = 1'b0;
        p_obj = kitchen_pkg::G_EMPTY;
        if (player_held == kitchen_pkg::P_NOTHING) begin   // putting down
            p_we = 1'b1;
            case (old_held)
                kitchen_pkg::P_ONION_WHOLE: p_obj = kitchen_pkg::G_ONION_WHOLE;
                kitchen_pkg::P_ONION_CHOPPED: begin
                    if (front_obj == kitchen_pkg::G_POT_EMPTY)  p_obj = kitchen_pkg::G_POT_RAW;
                    else if (front_obj == kitchen_pkg::G_EMPTY) p_obj = kitchen_pkg::G_ONION_CHOPPED;
                    else                                        p_we = 1'b0;
                end
                kitchen_pkg::P_POT_EMPTY: begin
                    if (front_obj == kitchen_pkg::G_ONION_CHOPPED) p_obj = kitchen_pkg::G_POT_RAW;
                    else if (front_obj == kitchen_pkg::G_EMPTY)    p_obj = kitchen_pkg::G_POT_EMPTY;
                    else                                           p_we = 1'b0;
                end
                kitchen_pkg::P_POT_RAW:    p_obj = kitchen_pkg::G_POT_RAW;
                kitchen_pkg::P_POT_COOKED: p_obj = kitchen_pkg::G_POT_COOKED;
                kitchen_pkg::P_EXT_OFF:    p_obj = kitchen_pkg::G_EXTINGUISHER;
                default:                   p_we = 1'b0;
            endcase
        end else if (player_held == kitchen_pkg::P_CHOPPING) begin
            p_we  = chop_done;   // front cell is the board here
            p_obj = kitchen_pkg::G_ONION_CHOPPED;
        end else if (old_held == kitchen_pkg::P_NOTHING) begin   // picking up
            p_we = 1'b1;
            if (at_crate && player_held == kitchen_pkg::P_ONION_WHOLE) begin
                p_obj = kitchen_pkg::G_ONION_WHOLE;   // crate never runs out
            end
        end else if (old_held == kitchen_pkg::P_POT_EMPTY
                     && player_held == kitchen_pkg::P_POT_RAW) begin
            p_we = 1'b1;
        end else if (player_held == kitchen_pkg::P_EXT_ON
                     && front_obj == kitchen_pkg::G_FIRE) begin
            p_we  = 1'b1;
            p_obj = kitchen_pkg::G_POT_EMPTY;
        end
        if (!play || !front_valid) p_we = 1'b0;
    end

endmodule

// File: object_grid.sv
`timescale 1ns/1ps

module object_grid (
    input  logic                     vsync,
    input  logic                     reset,
    input  kitchen_pkg::game_state_t game_state,
    input  logic                     p_we,
    input  kitchen_pkg::grid_x_t     p_wx,
    input  kitchen_pkg::grid_y_t     p_wy,
    input  kitchen_pkg::grid_obj_t   p_obj,
    input  logic                     s0_we,
    input  kitchen_pkg::grid_obj_t   s0_obj,
    input  logic                     s1_we,
    input  kitchen_pkg::grid_obj_t   s1_obj,
    output kitchen_pkg::grid_t       object_grid,
    output kitchen_pkg::grid_obj_t   front_obj,
    output kitchen_pkg::grid_obj_t   board_obj,
    output kitchen_pkg::grid_obj_t   stove0_obj,
    output kitchen_pkg::grid_obj_t   stove1_obj
);

    function automatic kitchen_pkg::grid_t start_layout();
        kitchen_pkg::grid_t g;
        g = '0;
        g[kitchen_pkg::CRATE_Y0][kitchen_pkg::CRATE_X]  = kitchen_pkg::G_ONION_WHOLE;
        g[kitchen_pkg::CRATE_Y1][kitchen_pkg::CRATE_X]  = kitchen_pkg::G_ONION_WHOLE;
        g[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE0_X]  = kitchen_pkg::G_POT_EMPTY;
        g[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE1_X]  = kitchen_pkg::G_POT_EMPTY;
        g[kitchen_pkg::EXT_Y][kitchen_pkg::EXT_X]       = kitchen_pkg::G_EXTINGUISHER;
        return g;
    endfunction

    always_ff @(posedge vsync) begin
        if (reset || game_state == kitchen_pkg::WELCOME) begin
            object_grid <= start_layout();
        end else begin
            if (p_we) object_grid[p_wy][p_wx] <= p_obj;
            // stoves come last so they override a player write to the same cell
            if (s0_we) object_grid[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE0_X] <= s0_obj;
            if (s1_we) object_grid[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE1_X] <= s1_obj;
        end
    end

    always_comb begin
        if (p_wx < kitchen_pkg::GRID_COLS) begin
            front_obj = kitchen_pkg::grid_obj_t'(object_grid[p_wy][p_wx]);
        end else begin
            front_obj = kitchen_pkg::G_EMPTY;   // past the right edge
        end
    end

    assign board_obj  = kitchen_pkg::grid_obj_t'(
                            object_grid[kitchen_pkg::BOARD_Y][kitchen_pkg::BOARD_X]);
    assign stove0_obj = kitchen_pkg::grid_obj_t'(
                            object_grid[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE0_X]);
    assign stove1_obj = kitchen_pkg::grid_obj_t'(
                            object_grid[kitchen_pkg::STOVE_Y][kitchen_pkg::STOVE1_X]);

endmodule

// File: kitchen_top.sv
`timescale 1ns/1ps

module kitchen_top (
    input  logic                     vsync,
    input  logic                     reset,
    input  kitchen_pkg::game_state_t game_state,
    input  kitchen_pkg::grid_x_t     player_x,
    input  kitchen_pkg::grid_y_t     player_y,
    input  kitchen_pkg::direction_t  player_direction,
    input  kitchen_pkg::held_t       player_held,
    output kitchen_pkg::grid_t       object_grid,
    output kitchen_pkg::timer_t      chop_left,
    output kitchen_pkg::timer_t      cook_left0,
    output kitchen_pkg::timer_t      cook_left1
);

    logic                   p_we;
    kitchen_pkg::grid_x_t   p_wx;
    kitchen_pkg::grid_y_t   p_wy;
    kitchen_pkg::grid_obj_t p_obj;
    kitchen_pkg::grid_obj_t front_obj;
    kitchen_pkg::grid_obj_t board_obj;
    logic                   s0_we;
    logic                   s1_we;
    kitchen_pkg::grid_obj_t s0_obj;
    kitchen_pkg::grid_obj_t s1_obj;
    kitchen_pkg::grid_obj_t stove0_obj;
    kitchen_pkg::grid_obj_t stove1_obj;

    player_action i_player_action (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .player_x(player_x), .player_y(player_y),
        .player_direction(player_direction), .player_held(player_held),
        .front_obj(front_obj), .board_obj(board_obj),
        .p_we(p_we), .p_wx(p_wx), .p_wy(p_wy), .p_obj(p_obj), .chop_left(chop_left)
    );

    stove_fsm #(.STOVE_X(kitchen_pkg::STOVE0_X)) stove0 (
        .vsync(vsync), .reset(reset), .game_state(game_state), .cell_obj(stove0_obj),
        .s_we(s0_we), .s_obj(s0_obj), .cook_left(cook_left0)
    );

    stove_fsm #(.STOVE_X(kitchen_pkg::STOVE1_X)) stove1 (
        .vsync(vsync), .reset(reset), .game_state(game_state), .cell_obj(stove1_obj),
        .s_we(s1_we), .s_obj(s1_obj), .cook_left(cook_left1)
    );

    object_grid i_object_grid (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .p_we(p_we), .p_wx(p_wx), .p_wy(p_wy), .p_obj(p_obj),
        .s0_we(s0_we), .s0_obj(s0_obj), .s1_we(s1_we), .s1_obj(s1_obj),
        .object_grid(object_grid), .front_obj(front_obj), .board_obj(board_obj),
        .stove0_obj(stove0_obj), .stove1_obj(stove1_obj)
    );

endmodule

// File: tb_kitchen_checks.svh
`ifndef TB_KITCHEN_CHECKS_SVH
`define TB_KITCHEN_CHECKS_SVH

task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_value(input string name, input int exp, input int act);
    assert (act == exp) else begin
        $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_cell(input string name, input int row, input int col,
                          input kitchen_pkg::grid_obj_t exp);
    check_value($sformatf("%s [%0d][%0d]", name, row, col), int'(exp), int'(grid[row][col]));
endtask

// start layout of the kitchen, row then column
function automatic kitchen_pkg::grid_obj_t expected_start_cell(input int row, input int col);
    if (col == 0 && (row == 2 || row == 3)) return kitchen_pkg::G_ONION_WHOLE;   // crates
    if (row == 0 && (col == 8 || col == 10)) return kitchen_pkg::G_POT_EMPTY;   // stoves
    if (row == 6 && col == 0) return kitchen_pkg::G_EXTINGUISHER;
    return kitchen_pkg::G_EMPTY;
endfunction

task automatic check_layout(input string name, input bit ext_taken);
    kitchen_pkg::grid_obj_t exp;
    for (int r = 0; r < kitchen_pkg::GRID_ROWS; r++) begin
        for (int c = 0; c < kitchen_pkg::GRID_COLS; c++) begin
            exp = expected_start_cell(r, c);
            if (ext_taken && r == 6 && c == 0) exp = kitchen_pkg::G_EMPTY;   // in hand
            check_cell(name, r, c, exp);
        end
    end
endtask

`endif

// File: tb_kitchen.sv
`timescale 1ns/1ps

module tb_kitchen;

    logic                     vsync;
    logic                     reset;
    kitchen_pkg::game_state_t game_state;
    kitchen_pkg::grid_x_t     player_x;
    kitchen_pkg::grid_y_t     player_y;
    kitchen_pkg::direction_t  player_direction;
    kitchen_pkg::held_t       player_held;
    kitchen_pkg::grid_t       grid;
    kitchen_pkg::timer_t      chop_left;
    kitchen_pkg::timer_t      cook_left0;
    kitchen_pkg::timer_t      cook_left1;

    `include "tb_kitchen_checks.svh"

    kitchen_top i_kitchen_top (
        .vsync(vsync), .reset(reset), .game_state(game_state),
        .player_x(player_x), .player_y(player_y),
        .player_direction(player_direction), .player_held(player_held),
        .object_grid(grid), .chop_left(chop_left),
        .cook_left0(cook_left0), .cook_left1(cook_left1)
    );

    initial begin
        vsync = 1'b0;
        forever #50 vsync = ~vsync;
    end

    task automatic next_frame();
        @(posedge vsync);
        @(negedge vsync);   // outputs settled, inputs change here
    endtask

    task automatic idle_frames();
        int n;
        n = $urandom_range(3);
        repeat (n) next_frame();
    endtask

    task automatic move_player(input int x, input int y, input kitchen_pkg::direction_t dir);
        player_x         = kitchen_pkg::grid_x_t'(x);
        player_y         = kitchen_pkg::grid_y_t'(y);
        player_direction = dir;
    endtask

    // bounded wait, stove 1 must stay untouched meanwhile
    task automatic wait_for_cell(input int row, input int col, input kitchen_pkg::grid_obj_t exp,
                                 input int limit, input string timeout_msg);
        int frames;
        frames = 0;
        while (grid[row][col] != exp && frames < limit) begin
            next_frame();
            frames++;
            check_cell("stove1_idle", 0, 10, kitchen_pkg::G_POT_EMPTY);
            check_value("stove1_timer", kitchen_pkg::COOK_FRAMES, int'(cook_left1));
        end
        if (grid[row][col] != exp) begin
            $display("%s", timeout_msg);
            stop_with_failure();
        end
    endtask

    task automatic take_onion();
        move_player(1, 2, kitchen_pkg::LEFT);
        player_held = kitchen_pkg::P_ONION_WHOLE;
        next_frame();
        check_cell("crate_pickup", 2, 0, kitchen_pkg::G_ONION_WHOLE);   // crate stays full
    endtask

    task automatic chop_onion(input bit with_pause);
        int used;
        move_player(2, 6, kitchen_pkg::DOWN);
        player_held = kitchen_pkg::P_NOTHING;
        next_frame();
        check_cell("board_load", 7, 2, kitchen_pkg::G_ONION_WHOLE);
        player_held = kitchen_pkg::P_CHOPPING;
        next_frame();
        used = 1;
        check_value("chop_start", kitchen_pkg::CHOP_FRAMES, int'(chop_left));   // loaded full
        if (with_pause) begin
            next_frame();
            used++;
            check_value("chop_falls", kitchen_pkg::CHOP_FRAMES - 1, int'(chop_left));
            game_state = kitchen_pkg::PAUSE;
            repeat (3) begin
                next_frame();
                check_value("chop_paused", kitchen_pkg::CHOP_FRAMES - 1, int'(chop_left));
            end
            game_state = kitchen_pkg::PLAY;
        end
        wait_for_cell(7, 2, kitchen_pkg::G_ONION_CHOPPED, kitchen_pkg::CHOP_FRAMES + 3 - used,
                      "chopping board never produced a chopped onion");
        player_held = kitchen_pkg::P_NOTHING;
        next_frame();
        player_held = kitchen_pkg::P_ONION_CHOPPED;
        next_frame();
        check_cell("board_pickup", 7, 2, kitchen_pkg::G_EMPTY);
    endtask

    task automatic cook_pot();
        move_player(8, 1, kitchen_pkg::UP);
        player_held = kitchen_pkg::P_NOTHING;
        next_frame();
        check_cell("pot_raw", 0, 8, kitchen_pkg::G_POT_RAW);
        check_value("cook_full", kitchen_pkg::COOK_FRAMES, int'(cook_left0));
        wait_for_cell(0, 8, kitchen_pkg::G_POT_COOKED, kitchen_pkg::COOK_FRAMES + 3,
                      "stove 0 never cooked");
        check_value("cook_zero", 0, int'(cook_left0));   // cooked once the timer ran out
    endtask

    initial begin
        void'($urandom(50));
        reset       = 1'b1;
        game_state  = kitchen_pkg::WELCOME;
        player_held = kitchen_pkg::P_NOTHING;
        move_player(1, 2, kitchen_pkg::LEFT);
        repeat (5) @(posedge vsync);
        @(negedge vsync);
        reset = 1'b0;
        check_layout("layout_reset", 1'b0);
        game_state = kitchen_pkg::PLAY;
        idle_frames();

        take_onion();
        move_player(5, 4, kitchen_pkg::RIGHT);
        idle_frames();
        player_held = kitchen_pkg::P_NOTHING;
        next_frame();
        check_cell("put_down", 4, 6, kitchen_pkg::G_ONION_WHOLE);
        player_held = kitchen_pkg::P_ONION_WHOLE;
        next_frame();
        check_cell("pick_up", 4, 6, kitchen_pkg::G_EMPTY);

        chop_onion(1'b1);
        cook_pot();
        wait_for_cell(0, 8, kitchen_pkg::G_FIRE, kitchen_pkg::BURN_FRAMES + 3,
                      "stove 0 never caught fire");

        move_player(1, 6, kitchen_pkg::LEFT);
        player_held = kitchen_pkg::P_EXT_OFF;
        next_frame();
        check_cell("ext_pickup", 6, 0, kitchen_pkg::G_EMPTY);
        move_player(8, 1, kitchen_pkg::UP);
        player_held = kitchen_pkg::P_EXT_ON;
        next_frame();
        check_cell("extinguish", 0, 8, kitchen_pkg::G_POT_EMPTY);
        player_held = kitchen_pkg::P_EXT_OFF;

        // dropping past the top edge
        move_player(3, 0, kitchen_pkg::UP);
        next_frame();
        player_held = kitchen_pkg::P_NOTHING;
        next_frame();
        check_layout("off_grid", 1'b1);
        idle_frames();

        take_onion();
        chop_onion(1'b0);
        cook_pot();

        game_state = kitchen_pkg::WELCOME;
        next_frame();
        check_layout("layout_welcome", 1'b0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
kitchen_pkg.sv
frame_timer.sv
stove_fsm.sv
player_action.sv
object_grid.sv
kitchen_top.sv
tb_kitchen.sv
